// ==== Makefile ====
# Verilator build for the MESI coherence testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		--top-module coherence_tb -f coherence_top.f

sim:
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module coherence_tb -f coherence_top.f \
		-Mdir obj_dir -o coherence_sim
	@out="$$(./obj_dir/coherence_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== coherence_top.f ====
common/mesi_pkg.sv
mesi_ctrl/cache_tag_array.sv
mesi_ctrl/mesi_ctrl.sv
rtl/wb_cmd_port.sv
rtl/coherence_resp.sv
rtl/coherence_top.sv
verif/coherence_tb.sv

// ==== common/mesi_pkg.sv ====
package mesi_pkg;

    // Cache geometry
    localparam int num_cores = 3;
    localparam int num_sets  = 4;
    localparam int num_ways  = 4;

    // Address fields of the 16-bit command address
    localparam int addr_w = 16;
    localparam int off_w  = 2;
    localparam int set_w  = $clog2(num_sets);
    localparam int tag_w  = addr_w - set_w - off_w;

    localparam int way_w = $clog2(num_ways);
    localparam int age_w = 2;
    localparam int pid_w = 2;
    localparam int cnt_w = 16;

    // Host-visible read registers
    localparam int reg_adr_w = 2;
    localparam logic [reg_adr_w-1:0] reg_last    = 2'd0;
    localparam logic [reg_adr_w-1:0] reg_bus_cnt = 2'd1;
    localparam logic [reg_adr_w-1:0] reg_wb_cnt  = 2'd2;

    typedef enum logic [1:0] {
        st_invalid   = 2'd0,
        st_shared    = 2'd1,
        st_exclusive = 2'd2,
        st_modified  = 2'd3
    } mesi_t;

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_flush = 2'd2
    } op_t;

    typedef enum logic [1:0] {
        bus_none = 2'd0,
        bus_rd   = 2'd1,
        bus_rdx  = 2'd2,
        bus_upgr = 2'd3
    } bus_op_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [set_w-1:0] set;
        logic [off_w-1:0] offset;
    } addr_t;

    // Lives in the low 20 bits of the Wishbone write data
    typedef struct packed {
        logic [pid_w-1:0] pid;
        op_t              op;
        addr_t            addr;
    } cmd_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        mesi_t            state;
        logic [age_w-1:0] age;
    } line_t;

    typedef struct packed {
        logic                 hit;
        bus_op_t              bus_op;
        mesi_t                state;
        logic                 wb;
        logic [num_cores-1:0] snoop;
        logic [way_w-1:0]     way;
        logic                 spare;
    } result_t;

endpackage

// ==== mesi_ctrl/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic [mesi_pkg::set_w-1:0]      rd_set_i,
    input  logic [mesi_pkg::tag_w-1:0]      rd_tag_i,
    output mesi_pkg::line_t                 rd_lines_o [mesi_pkg::num_ways],
    output logic [mesi_pkg::num_ways-1:0]   hit_ways_o,
    input  logic                            wr_en_i,
    input  logic [mesi_pkg::set_w-1:0]      wr_set_i,
    input  logic [mesi_pkg::way_w-1:0]      wr_way_i,
    input  mesi_pkg::line_t                 wr_line_i,
    input  logic                            age_en_i
);
    import mesi_pkg::*;

    line_t            lines_q [num_sets][num_ways];
    line_t            set_nxt [num_ways];
    logic [tag_w-1:0] rd_tag_q;
    logic [age_w-1:0] old_age;

    // Next contents of the set being updated
    always_comb begin
        old_age = lines_q[wr_set_i][wr_way_i].age;
        for (int w = 0; w < num_ways; w++) begin
            set_nxt[w] = lines_q[wr_set_i][w];
            if (age_en_i) begin
                if (way_w'(w) == wr_way_i) begin
                    set_nxt[w].age = 2'd3;
                end else if (set_nxt[w].age > old_age) begin
                    set_nxt[w].age = set_nxt[w].age - 2'd1;
                end
            end
        end
        if (wr_en_i) begin
            set_nxt[wr_way_i].tag   = wr_line_i.tag;
            set_nxt[wr_way_i].state = wr_line_i.state;
            // A touched line is always most recent
            if (!age_en_i) set_nxt[wr_way_i].age = wr_line_i.age;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    lines_q[s][w].tag   <= '0;
                    lines_q[s][w].state <= st_invalid;
                    lines_q[s][w].age   <= age_w'(w);
                end
            end
        end else if (wr_en_i || age_en_i) begin
            for (int w = 0; w < num_ways; w++) begin
                lines_q[wr_set_i][w] <= set_nxt[w];
            end
        end
    end

    // Registered read of one set
    always_ff @(posedge clk) begin
        rd_tag_q <= rd_tag_i;
        for (int w = 0; w < num_ways; w++) begin
            rd_lines_o[w] <= lines_q[rd_set_i][w];
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_ways_o[w] = (rd_lines_o[w].state != st_invalid) &&
                            (rd_lines_o[w].tag == rd_tag_q);
        end
    end

endmodule

// ==== mesi_ctrl/mesi_ctrl.sv ====
`timescale 1ns/1ps

module mesi_ctrl (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              cmd_valid_i,
    input  mesi_pkg::cmd_t    cmd_i,
    output logic              res_valid_o,
    output mesi_pkg::result_t res_o
);
    import mesi_pkg::*;

    logic                 lookup_q;
    line_t                lines [num_cores][num_ways];
    logic [num_ways-1:0]  hit_ways [num_cores];
    logic [way_w-1:0]     hit_way [num_cores];
    logic [num_cores-1:0] hit;
    logic [num_cores-1:0] is_req;
    logic [num_cores-1:0] snoop_hit;
    logic [num_cores-1:0] snoop_wb;
    mesi_t                snoop_state [num_cores];
    mesi_t                snoop_next [num_cores];
    line_t                req_lines [num_ways];
    logic                 req_hit;
    logic [way_w-1:0]     req_way;
    logic [way_w-1:0]     victim_way;
    logic [way_w-1:0]     way_used;
    mesi_t                req_state;
    mesi_t                req_next;
    logic                 victim_dirty;
    logic                 req_wb;
    bus_op_t              bus_op;
    logic                 to_shared;
    logic                 to_invalid;
    logic                 upd_req;
    logic                 age_upd;
    logic [num_cores-1:0] wr_en;
    logic [num_cores-1:0] age_en;
    logic [way_w-1:0]     wr_way [num_cores];
    line_t                wr_line [num_cores];

    // One-hot hit vector to way number
    function automatic logic [way_w-1:0] enc_way(input logic [num_ways-1:0] oh);
        logic [way_w-1:0] w;
        w = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (oh[i]) w = w | way_w'(i);
        end
        return w;
    endfunction

    // Lookup data arrives one cycle after the command
    always_ff @(posedge clk) begin
        if (rst_i) lookup_q <= 1'b0;
        else lookup_q <= cmd_valid_i;
    end

    assign res_valid_o = lookup_q;

    for (genvar c = 0; c < num_cores; c++) begin : g_core
        cache_tag_array u_tags (
            .clk        (clk),
            .rst_i      (rst_i),
            .rd_set_i   (cmd_i.addr.set),
            .rd_tag_i   (cmd_i.addr.tag),
            .rd_lines_o (lines[c]),
            .hit_ways_o (hit_ways[c]),
            .wr_en_i    (wr_en[c]),
            .wr_set_i   (cmd_i.addr.set),
            .wr_way_i   (wr_way[c]),
            .wr_line_i  (wr_line[c]),
            .age_en_i   (age_en[c])
        );

        assign hit[c]         = |hit_ways[c];
        assign hit_way[c]     = enc_way(hit_ways[c]);
        assign is_req[c]      = (cmd_i.pid == pid_w'(c));
        assign snoop_hit[c]   = hit[c] & ~is_req[c];
        assign snoop_state[c] = lines[c][hit_way[c]].state;
    end

    // Requester view of its own set
    always_comb begin
        req_hit = 1'b0;
        req_way = '0;
        for (int w = 0; w < num_ways; w++) req_lines[w] = '0;
        for (int c = 0; c < num_cores; c++) begin
            if (is_req[c]) begin
                req_hit = hit[c];
                req_way = hit_way[c];
                for (int w = 0; w < num_ways; w++) req_lines[w] = lines[c][w];
            end
        end
    end

    // Victim is the lowest invalid way, else the LRU way
    always_comb begin
        logic [way_w-1:0] inv_way;
        logic [way_w-1:0] lru_way;
        logic             has_inv;
        inv_way = '0;
        lru_way = '0;
        has_inv = 1'b0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (req_lines[w].state == st_invalid) begin
                inv_way = way_w'(w);
                has_inv = 1'b1;
            end
            if (req_lines[w].age == '0) lru_way = way_w'(w);
        end
        victim_way = has_inv ? inv_way : lru_way;
    end

    assign req_state    = req_hit ? req_lines[req_way].state : st_invalid;
    assign victim_dirty = (req_lines[victim_way].state == st_modified);

    always_comb begin
        bus_op     = bus_none;
        req_next   = req_state;
        req_wb     = 1'b0;
        to_shared  = 1'b0;
        to_invalid = 1'b0;
        upd_req    = 1'b0;
        age_upd    = 1'b0;
        way_used   = req_way;
        case (cmd_i.op)
            op_read: begin
                upd_req = 1'b1;
                age_upd = 1'b1;
                if (!req_hit) begin
                    bus_op    = bus_rd;
                    to_shared = 1'b1;
                    req_next  = (|snoop_hit) ? st_shared : st_exclusive;
                    way_used  = victim_way;
                    req_wb    = victim_dirty;
                end
            end
            op_write: begin
                upd_req  = 1'b1;
                age_upd  = 1'b1;
                req_next = st_modified;
                if (!req_hit) begin
                    bus_op     = bus_rdx;
                    to_invalid = 1'b1;
                    way_used   = victim_way;
                    req_wb     = victim_dirty;
                end else if (req_state == st_shared) begin
                    bus_op     = bus_upgr;
                    to_invalid = 1'b1;
                end
            end
            op_flush: begin
                if (req_hit) begin
                    upd_req  = 1'b1;
                    req_next = st_invalid;
                    req_wb   = (req_state == st_modified);
                end else begin
                    way_used = '0;
                end
            end
            default: way_used = '0;
        endcase
    end

    // Snooper downgrades and invalidations
    always_comb begin
        for (int c = 0; c < num_cores; c++) begin
            snoop_next[c] = snoop_state[c];
            if (snoop_hit[c] && to_invalid) snoop_next[c] = st_invalid;
            else if (snoop_hit[c] && to_shared) snoop_next[c] = st_shared;
            snoop_wb[c] = snoop_hit[c] & (to_invalid | to_shared) &
                          (snoop_state[c] == st_modified);
        end
    end

    always_comb begin
        for (int c = 0; c < num_cores; c++) begin
            if (is_req[c]) begin
                wr_en[c]         = lookup_q & upd_req;
                age_en[c]        = lookup_q & age_upd;
                wr_way[c]        = way_used;
                wr_line[c].tag   = cmd_i.addr.tag;
                wr_line[c].state = req_next;
                wr_line[c].age   = req_lines[way_used].age;
            end else begin
                wr_en[c]         = lookup_q & snoop_hit[c] & (to_shared | to_invalid);
                age_en[c]        = 1'b0;
                wr_way[c]        = hit_way[c];
                wr_line[c]       = lines[c][hit_way[c]];
                wr_line[c].state = snoop_next[c];
            end
        end
    end

    always_comb begin
        res_o.hit    = req_hit;
        res_o.bus_op = bus_op;
        res_o.state  = req_next;
        res_o.wb     = req_wb | (|snoop_wb);
        res_o.snoop  = snoop_hit;
        res_o.way    = way_used;
        res_o.spare  = 1'b0;
    end

endmodule

// ==== rtl/coherence_resp.sv ====
`timescale 1ns/1ps

module coherence_resp (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           res_valid_i,
    input  mesi_pkg::result_t              res_i,
    input  logic [mesi_pkg::reg_adr_w-1:0] rd_adr_i,
    output logic [31:0]                    rd_data_o
);
    import mesi_pkg::*;

    result_t          last_q;
    logic [cnt_w-1:0] bus_cnt_q;
    logic [cnt_w-1:0] wb_cnt_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            last_q    <= '0;
            bus_cnt_q <= '0;
            wb_cnt_q  <= '0;
        end else if (res_valid_i) begin
            last_q <= res_i;
            // Both counters stick at all ones
            if (res_i.bus_op != bus_none && bus_cnt_q != '1) begin
                bus_cnt_q <= bus_cnt_q + cnt_w'(1);
            end
            if (res_i.wb && wb_cnt_q != '1) begin
                wb_cnt_q <= wb_cnt_q + cnt_w'(1);
            end
        end
    end

    always_comb begin
        case (rd_adr_i)
            reg_last:    rd_data_o = 32'(last_q);
            reg_bus_cnt: rd_data_o = 32'(bus_cnt_q);
            reg_wb_cnt:  rd_data_o = 32'(wb_cnt_q);
            default:     rd_data_o = '0;
        endcase
    end

endmodule

// ==== rtl/coherence_top.sv ====
`timescale 1ns/1ps

module coherence_top (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [1:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o
);
    import mesi_pkg::*;

    logic                 cmd_valid;
    cmd_t                 cmd;
    logic                 res_valid;
    result_t              res;
    logic [31:0]          rd_data;
    logic [reg_adr_w-1:0] rd_adr;

    wb_cmd_port u_port (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .res_valid_i (res_valid),
        .rd_data_i   (rd_data),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd),
        .rd_adr_o    (rd_adr)
    );

    mesi_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    coherence_resp u_resp (
        .clk         (clk),
        .rst_i       (rst_i),
        .res_valid_i (res_valid),
        .res_i       (res),
        .rd_adr_i    (rd_adr),
        .rd_data_o   (rd_data)
    );

endmodule

// ==== rtl/wb_cmd_port.sv ====
`timescale 1ns/1ps

module wb_cmd_port (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [1:0]                       wb_adr_i,
    input  logic [31:0]                      wb_dat_i,
    output logic                             wb_ack_o,
    output logic [31:0]                      wb_dat_o,
    input  logic                             res_valid_i,
    input  logic [31:0]                      rd_data_i,
    output logic                             cmd_valid_o,
    output mesi_pkg::cmd_t                   cmd_o,
    output logic [mesi_pkg::reg_adr_w-1:0]   rd_adr_o
);
    import mesi_pkg::*;

    typedef enum logic [1:0] {
        ps_idle,
        ps_busy,
        ps_ack
    } port_state_t;

    port_state_t state_q;
    logic        req;

    assign req      = wb_cyc_i & wb_stb_i;
    assign wb_ack_o = (state_q == ps_ack);
    // Master holds adr until ack, so the read select can follow it directly
    assign rd_adr_o = wb_adr_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= ps_idle;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            case (state_q)
                ps_idle: begin
                    if (req && wb_we_i) begin
                        cmd_valid_o <= 1'b1;
                        state_q     <= ps_busy;
                    end else if (req) begin
                        state_q <= ps_ack;
                    end
                end
                // Wait for the controller to finish the lookup and update
                ps_busy: if (res_valid_i) state_q <= ps_ack;
                default: state_q <= ps_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ps_idle && req) begin
            if (wb_we_i) cmd_o <= cmd_t'(wb_dat_i[$bits(cmd_t)-1:0]);
            else wb_dat_o <= rd_data_i;
        end
    end

endmodule

// ==== verif/coherence_stim.txt ====
# name  pid  op (0 read, 1 write, 2 flush)  address (hex)  expected result word (hex)
# final line: totals  expected bus operation count  expected write-back count
cold_rd_miss     0 0 0100 300
rd_hit_excl      0 0 0100 900
share_p1         1 0 0100 288
share_p2         2 0 0100 298
upgrade_p1       1 1 0100 fa8
rd_after_mod     0 0 0100 2d0
rd_hit_shared    0 0 0100 890
wr_miss_p2       2 1 0100 598
wr_miss_snoop_m  0 1 0100 5e0
p2_rd_excl       2 0 0204 300
p2_wr_silent     2 1 0204 980
p2_flush_mod     2 2 0204 840
p2_flush_miss    2 2 0204 000
lru_rd_a         0 0 0318 300
lru_rd_b         0 0 0328 302
lru_wr_b         0 1 0328 982
lru_rd_c         0 0 0338 304
lru_rd_d         0 0 0348 306
lru_hit_a        0 0 0318 900
lru_rd_e_evict   0 0 0358 342
lru_rd_b_again   0 0 0328 304
totals 14 4

// ==== verif/coherence_tb.sv ====
`timescale 1ns/1ps

module coherence_tb;
    import mesi_pkg::*;

    localparam int name_w            = 8 * 16;
    localparam int reset_cycles      = 5;
    localparam int cycles_per_vector = 20;
    localparam logic [name_w-1:0] comment_tok = "#";
    localparam logic [name_w-1:0] totals_tok  = "totals";

    logic        clk;
    logic        rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [1:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;

    // Vectors loaded from the stim file
    logic [name_w-1:0] name_q [$];
    logic [1:0]        pid_q [$];
    logic [1:0]        op_q [$];
    logic [15:0]       addr_q [$];
    logic [11:0]       exp_q [$];
    int                exp_bus;
    int                exp_wb;
    logic              have_totals;
    logic              loaded;
    int                watchdog_cycles;
    int                errors;
    int                checks;
    logic [31:0]       rd_data;

    coherence_top coherence_top_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Turns a packed name into printable text without its leading nulls
    function automatic string to_text(input logic [name_w-1:0] v);
        string      s;
        logic [7:0] c;
        s = "";
        for (int i = name_w / 8 - 1; i >= 0; i--) begin
            c = v[i*8 +: 8];
            if (c != 8'd0) s = {s, $sformatf("%c", c)};
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // One Wishbone write; ack is expected in the fourth cycle counted from stb
    task automatic write_cmd(input string name, input logic [31:0] data);
        int waited;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = reg_last;
        wb_dat_i = data;
        waited   = 1;
        @(negedge clk);
        while (wb_ack_o !== 1'b1) begin
            waited++;
            @(negedge clk);
        end
        check_value({name, " latency"}, 32'd3, 32'(waited));
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        @(negedge clk);
        while (wb_ack_o !== 1'b1) @(negedge clk);
        data     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic load_stim();
        int                fd;
        int                n;
        int                pid;
        int                op;
        logic [name_w-1:0] token;
        logic [8*256-1:0]  rest;
        logic [15:0]       addr;
        logic [11:0]       expected;
        logic              done;
        fd = $fopen("verif/coherence_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/coherence_stim.txt");
            errors++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", token);
            if (n != 1) begin
                done = 1'b1;
            end else if (token == comment_tok) begin
                n = $fgets(rest, fd);
            end else if (token == totals_tok) begin
                n = $fscanf(fd, "%d %d", exp_bus, exp_wb);
                have_totals = (n == 2);
            end else begin
                n = $fscanf(fd, "%d %d %h %h", pid, op, addr, expected);
                if (n != 4) begin
                    $display("Stimulus line for %s is incomplete", to_text(token));
                    errors++;
                    done = 1'b1;
                end else begin
                    name_q.push_back(token);
                    pid_q.push_back(2'(pid));
                    op_q.push_back(2'(op));
                    addr_q.push_back(addr);
                    exp_q.push_back(expected);
                end
            end
        end
        $fclose(fd);
        if (!have_totals) begin
            $display("The stimulus file has no totals line");
            errors++;
        end
    endtask

    initial begin
        rst_i       = 1'b1;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        errors      = 0;
        checks      = 0;
        exp_bus     = 0;
        exp_wb      = 0;
        have_totals = 1'b0;
        loaded      = 1'b0;
        load_stim();
        // Two extra slots cover the reset reads and the counter reads
        watchdog_cycles = (name_q.size() + 2) * cycles_per_vector + reset_cycles;
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // Result word and counters start at zero
        read_reg(reg_last, rd_data);
        check_value("reset_last", 32'd0, rd_data);
        read_reg(reg_bus_cnt, rd_data);
        check_value("reset_bus_count", 32'd0, rd_data);
        read_reg(reg_wb_cnt, rd_data);
        check_value("reset_wb_count", 32'd0, rd_data);

        foreach (name_q[i]) begin
            write_cmd(to_text(name_q[i]), {12'd0, pid_q[i], op_q[i], addr_q[i]});
            read_reg(reg_last, rd_data);
            check_value(to_text(name_q[i]), {20'd0, exp_q[i]}, rd_data);
        end

        if (have_totals) begin
            read_reg(reg_bus_cnt, rd_data);
            check_value("bus_count", 32'(exp_bus), rd_data);
            read_reg(reg_wb_cnt, rd_data);
            check_value("wb_count", 32'(exp_wb), rd_data);
        end

        $display("Finished %0d checks with %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Bounds the run by the number of vectors read
    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the DUT did not complete the test sequence in time");
        $display("Errors found");
        $finish;
    end

endmodule
